/* all.f */
common/raycast_pkg.sv
delta_dist/recip_divider.sv
delta_dist/delta_dist_unit.sv
rtl/ray_fifo.sv
ray_setup/ray_setup.sv
rtl/raycast_top.sv
verification/tb_raycast.sv

/* Bender.yml */
package:
  name: raycast

sources:
  - files:
      - common/raycast_pkg.sv
      - delta_dist/recip_divider.sv
      - delta_dist/delta_dist_unit.sv
      - rtl/ray_fifo.sv
      - ray_setup/ray_setup.sv
      - rtl/raycast_top.sv
  - target: test
    files:
      - verification/tb_raycast.sv

/* verification/raycast_tests.txt */
# name pose back_pressure_pct spot_col dir_x dir_y step_x step_y delta_x delta_y
# pose, percentage, column and steps in decimal, directions and deltas in hex
# one line per frame, frames run in file order
p0_free 0 0 0 0100 ff57 0 1 0100 0183
p0_center 0 70 160 0100 0000 0 0 0100 ffff
p0_edge 0 30 319 0100 00a7 0 0 0100 0188
p0_tiny 0 50 162 0100 0001 0 0 0100 ffff
p0_neg_two 0 0 159 0100 fffe 0 1 0100 8000
p0_mid 0 70 100 0100 ffc0 0 1 0100 0400
p0_quarter 0 10 80 0100 ffab 0 1 0100 0303
p1_free 1 0 0 ff00 ff57 1 1 0100 0183
p1_edge 1 70 319 ff00 00a7 1 0 0100 0188
p1_mid 1 20 100 ff00 ffc0 1 1 0100 0400
p1_tiny 1 90 162 ff00 0001 1 0 0100 ffff
p2_center 2 0 160 ff00 0000 1 0 0100 ffff
p2_first 2 70 0 ff00 ff57 1 1 0100 0183
p2_edge 2 40 319 ff00 00a7 1 0 0100 0188
p2_neg_two 2 0 159 ff00 fffe 1 1 0100 8000
p3_free 3 0 0 ff57 0100 1 0 0183 0100
p3_center 3 70 160 0000 0100 0 0 ffff 0100
p3_edge 3 20 319 00a7 0100 0 0 0188 0100
p3_neg_two 3 90 159 fffe 0100 1 0 8000 0100
p3_three_q 3 0 240 0054 0100 0 0 030c 0100
p3_tiny 3 70 162 0001 0100 0 0 ffff 0100
p3_quarter 3 50 80 ffab 0100 1 0 0303 0100

/* verification/tb_raycast.sv */
`default_nettype none

module tb_raycast;

    localparam int num_columns = 320;
    localparam int fifo_depth = 16;
    localparam int max_tests = 32;
    localparam int drive_delay = 1;
    // start edge to first ray_valid with an empty pipeline
    localparam int min_latency = 21;
    localparam tests_file = "verification/raycast_tests.txt";

    logic clk_pixel;
    logic sys_rst;
    logic [raycast_pkg::pose_sel_width-1:0] pose_sel;
    logic start;
    logic ray_ready;
    logic busy;
    logic ray_valid;
    logic [raycast_pkg::column_width-1:0] ray_column;
    logic ray_last;
    logic [15:0] ray_dir_x;
    logic [15:0] ray_dir_y;
    logic step_x;
    logic step_y;
    logic [15:0] delta_dist_x;
    logic [15:0] delta_dist_y;

    // test table from the data file
    string test_name [max_tests];
    int test_pose [max_tests];
    int test_bp [max_tests];
    int spot_col [max_tests];
    logic [15:0] spot_dir_x [max_tests];
    logic [15:0] spot_dir_y [max_tests];
    logic spot_step_x [max_tests];
    logic spot_step_y [max_tests];
    logic [15:0] spot_delta_x [max_tests];
    logic [15:0] spot_delta_y [max_tests];
    int num_tests;
    bit tests_loaded;

    raycast_top #(
        .num_columns(num_columns),
        .fifo_depth(fifo_depth)
    ) raycast_top_inst (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .pose_sel(pose_sel),
        .start(start),
        .ray_ready(ray_ready),
        .busy(busy),
        .ray_valid(ray_valid),
        .ray_column(ray_column),
        .ray_last(ray_last),
        .ray_dir_x(ray_dir_x),
        .ray_dir_y(ray_dir_y),
        .step_x(step_x),
        .step_y(step_y),
        .delta_dist_x(delta_dist_x),
        .delta_dist_y(delta_dist_y)
    );

    // period 8
    always #4 clk_pixel = ~clk_pixel;

    // ************************************************************
    // reference model
    // ************************************************************

    // dir + ((plane * camera_x) >>> 8), wrapped to 16 bits
    function automatic logic [15:0] expected_dir(input logic [15:0] base,
                                                 input logic [15:0] plane, input int col);
        int cam;
        int prod;
        cam = (col * 512) / num_columns - 256;
        prod = int'($signed(plane)) * cam;
        return base + 16'(prod >>> 8);
    endfunction

    // 65536 / |dir|, saturated on zero or overflow
    function automatic logic [15:0] expected_recip(input logic [15:0] dir);
        int mag;
        int quo;
        mag = dir[15] ? 65536 - int'(dir) : int'(dir);
        if (mag == 0) return raycast_pkg::recip_saturate;
        quo = 65536 / mag;
        if (quo > 65535) return raycast_pkg::recip_saturate;
        return 16'(quo);
    endfunction

    task automatic value_error(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %s: %s expected 0x%0h actual 0x%0h", name, field, exp, act);
        $display(">>> FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic protocol_error(input string what);
        $display("ERROR: %s", what);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    // inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk_pixel);
        #drive_delay;
    endtask

    task automatic load_tests();
        int fd;
        int n;
        int pose;
        int bp;
        int col;
        int sx;
        int sy;
        string line;
        string name;
        logic [15:0] dx;
        logic [15:0] dy;
        logic [15:0] ddx;
        logic [15:0] ddy;
        fd = $fopen(tests_file, "r");
        assert (fd != 0) else protocol_error("cannot open the test file");
        num_tests = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // skip comments and blank lines
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %d %d %d %h %h %d %d %h %h",
                            name, pose, bp, col, dx, dy, sx, sy, ddx, ddy);
                assert (n == 10) else protocol_error("malformed line in the test file");
                assert (num_tests < max_tests) else protocol_error("too many tests in the file");
                test_name[num_tests] = name;
                test_pose[num_tests] = pose;
                test_bp[num_tests] = bp;
                spot_col[num_tests] = col;
                spot_dir_x[num_tests] = dx;
                spot_dir_y[num_tests] = dy;
                spot_step_x[num_tests] = sx[0];
                spot_step_y[num_tests] = sy[0];
                spot_delta_x[num_tests] = ddx;
                spot_delta_y[num_tests] = ddy;
                num_tests++;
            end
        end
        $fclose(fd);
        assert (num_tests > 0) else protocol_error("the test file holds no tests");
    endtask

    // one accepted record against the model and the file's spot values
    task automatic check_record(input int t, input int col);
        int p;
        logic [15:0] exp_x;
        logic [15:0] exp_y;
        string nm;
        p = test_pose[t];
        nm = test_name[t];
        exp_x = expected_dir(raycast_pkg::pose_dir_x[p], raycast_pkg::pose_plane_x[p], col);
        exp_y = expected_dir(raycast_pkg::pose_dir_y[p], raycast_pkg::pose_plane_y[p], col);
        assert (ray_column == 9'(col)) else value_error(nm, "ray_column", col, ray_column);
        assert (ray_last == (col == num_columns - 1))
            else value_error(nm, "ray_last", (col == num_columns - 1), ray_last);
        assert (ray_dir_x == exp_x) else value_error(nm, "ray_dir_x", exp_x, ray_dir_x);
        assert (ray_dir_y == exp_y) else value_error(nm, "ray_dir_y", exp_y, ray_dir_y);
        // negative component steps left or down
        assert (step_x == exp_x[15]) else value_error(nm, "step_x", exp_x[15], step_x);
        assert (step_y == exp_y[15]) else value_error(nm, "step_y", exp_y[15], step_y);
        assert (delta_dist_x == expected_recip(exp_x))
            else value_error(nm, "delta_dist_x", expected_recip(exp_x), delta_dist_x);
        assert (delta_dist_y == expected_recip(exp_y))
            else value_error(nm, "delta_dist_y", expected_recip(exp_y), delta_dist_y);
        if (col == spot_col[t]) begin
            assert (ray_dir_x == spot_dir_x[t])
                else value_error(nm, "spot ray_dir_x", spot_dir_x[t], ray_dir_x);
            assert (ray_dir_y == spot_dir_y[t])
                else value_error(nm, "spot ray_dir_y", spot_dir_y[t], ray_dir_y);
            assert (step_x == spot_step_x[t])
                else value_error(nm, "spot step_x", spot_step_x[t], step_x);
            assert (step_y == spot_step_y[t])
                else value_error(nm, "spot step_y", spot_step_y[t], step_y);
            assert (delta_dist_x == spot_delta_x[t])
                else value_error(nm, "spot delta_dist_x", spot_delta_x[t], delta_dist_x);
            assert (delta_dist_y == spot_delta_y[t])
                else value_error(nm, "spot delta_dist_y", spot_delta_y[t], delta_dist_y);
        end
    endtask

    // ************************************************************
    // one frame: start, ignored restart, drain with back-pressure
    // ************************************************************
    task automatic run_frame(input int t);
        int cyc;
        int col;
        int other;
        bit finished;
        bit held;
        bit rdy;
        logic [raycast_pkg::column_width-1:0] snap_col;
        logic [15:0] snap_dx;
        logic [15:0] snap_dy;
        other = (test_pose[t] + 2) % 4;
        assert (busy == 1'b0 && ray_valid == 1'b0) else protocol_error("DUT not idle at start");
        pose_sel = 2'(test_pose[t]);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        assert (busy == 1'b1) else protocol_error("busy did not rise after start");
        cyc = 0;
        col = 0;
        finished = 1'b0;
        held = 1'b0;
        while (!finished) begin
            // restart with another pose while busy, must be ignored
            if (cyc == 5) begin
                assert (busy == 1'b1) else protocol_error("busy fell early in the frame");
                pose_sel = 2'(other);
                start = 1'b1;
            end else if (cyc == 6) begin
                start = 1'b0;
            end
            if (held) begin
                assert (ray_valid == 1'b1) else protocol_error("ray_valid dropped while stalled");
                assert (ray_column == snap_col && delta_dist_x == snap_dx
                        && delta_dist_y == snap_dy)
                    else protocol_error("output record changed while stalled");
            end
            if (ray_valid && col == 0 && !held) begin
                assert (cyc >= min_latency) else protocol_error("first ray came too early");
            end
            rdy = ($urandom % 100) >= test_bp[t];
            ray_ready = rdy;
            // transfer on the coming edge
            if (ray_valid && rdy) begin
                check_record(t, col);
                finished = ray_last;
                col++;
            end
            held = ray_valid && !rdy;
            snap_col = ray_column;
            snap_dx = delta_dist_x;
            snap_dy = delta_dist_y;
            next_cycle();
            cyc++;
        end
        ray_ready = 1'b0;
        assert (col == num_columns) else value_error(test_name[t], "record count", num_columns, col);
        assert (busy == 1'b0) else protocol_error("busy still high after the last ray");
        assert (ray_valid == 1'b0) else protocol_error("extra ray after the last one");
    endtask

    // watchdog sized from the number of frames
    initial begin
        int watchdog_cycles;
        wait (tests_loaded);
        watchdog_cycles = num_tests * num_columns * 19 * 4 + 1000;
        repeat (watchdog_cycles) @(posedge clk_pixel);
        protocol_error($sformatf("timeout, frames not done after %0d cycles", watchdog_cycles));
    end

    initial begin
        int t;
        clk_pixel = 1'b0;
        sys_rst = 1'b1;
        pose_sel = '0;
        start = 1'b0;
        ray_ready = 1'b0;
        tests_loaded = 1'b0;
        void'($urandom(52));
        load_tests();
        tests_loaded = 1'b1;
        repeat (4) @(posedge clk_pixel);
        #drive_delay;
        sys_rst = 1'b0;
        // quiet until the first start
        repeat (8) begin
            assert (ray_valid == 1'b0 && busy == 1'b0)
                else protocol_error("ray_valid or busy high before the first start");
            next_cycle();
        end
        for (t = 0; t < num_tests; t++) begin
            run_frame(t);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/raycast_top.sv */
`default_nettype none

module raycast_top #(
    parameter int num_columns = 320,
    parameter int fifo_depth = 16
) (
    input logic clk_pixel,
    input logic sys_rst,
    input logic [raycast_pkg::pose_sel_width-1:0] pose_sel,
    input logic start,
    input logic ray_ready,
    output logic busy,
    output logic ray_valid,
    output logic [raycast_pkg::column_width-1:0] ray_column,
    output logic ray_last,
    output logic [raycast_pkg::fixed_width-1:0] ray_dir_x,
    output logic [raycast_pkg::fixed_width-1:0] ray_dir_y,
    output logic step_x,
    output logic step_y,
    output logic [raycast_pkg::fixed_width-1:0] delta_dist_x,
    output logic [raycast_pkg::fixed_width-1:0] delta_dist_y
);

    // setup to fifo stream
    logic setup_valid;
    logic setup_ready;
    logic [raycast_pkg::setup_rec_width-1:0] setup_rec;

    // fifo to reciprocal unit stream
    logic fifo_valid;
    logic fifo_ready;
    logic [raycast_pkg::setup_rec_width-1:0] fifo_rec;

    // producer, one record per screen column
    ray_setup #(
        .num_columns(num_columns)
    ) ray_setup_inst (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .pose_sel(pose_sel),
        .start(start),
        .setup_ready(setup_ready),
        .busy(busy),
        .setup_valid(setup_valid),
        .setup_rec(setup_rec)
    );

    // absorbs the divider latency
    ray_fifo #(
        .fifo_depth(fifo_depth),
        .width(raycast_pkg::setup_rec_width)
    ) ray_fifo_inst (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .setup_valid(setup_valid),
        .setup_rec(setup_rec),
        .fifo_ready(fifo_ready),
        .setup_ready(setup_ready),
        .fifo_valid(fifo_valid),
        .fifo_rec(fifo_rec)
    );

    // consumer, delta distances per axis
    delta_dist_unit delta_dist_unit_inst (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .fifo_valid(fifo_valid),
        .fifo_rec(fifo_rec),
        .ray_ready(ray_ready),
        .fifo_ready(fifo_ready),
        .ray_valid(ray_valid),
        .ray_column(ray_column),
        .ray_last(ray_last),
        .ray_dir_x(ray_dir_x),
        .ray_dir_y(ray_dir_y),
        .step_x(step_x),
        .step_y(step_y),
        .delta_dist_x(delta_dist_x),
        .delta_dist_y(delta_dist_y)
    );

endmodule

`default_nettype wire

/* ray_setup/ray_setup.sv */
`default_nettype none

module ray_setup #(
    parameter int num_columns = 320
) (
    input logic clk_pixel,
    input logic sys_rst,
    input logic [raycast_pkg::pose_sel_width-1:0] pose_sel,
    input logic start,
    input logic setup_ready,
    output logic busy,
    output logic setup_valid,
    output logic [raycast_pkg::setup_rec_width-1:0] setup_rec
);

    localparam int fw = raycast_pkg::fixed_width;
    localparam int cw = raycast_pkg::column_width;
    localparam logic [cw+8:0] num_cols_w = (cw+9)'(num_columns);
    localparam logic [cw-1:0] last_col = cw'(num_columns - 1);

    // frame control
    logic [raycast_pkg::pose_sel_width-1:0] pose_q;
    logic [cw-1:0] col_cnt;
    logic issuing;
    logic advance;
    logic issue;

    // camera_x and plane products
    logic [cw+8:0] cam_scaled;
    logic [cw+8:0] cam_div;
    logic signed [9:0] camera_x;
    logic signed [25:0] prod_x;
    logic signed [25:0] prod_y;

    // stage one registers
    logic s1_valid;
    logic [cw-1:0] s1_col;
    logic s1_last;
    logic signed [25:0] s1_prod_x;
    logic signed [25:0] s1_prod_y;

    // stage two sums
    logic [fw-1:0] ray_dir_x;
    logic [fw-1:0] ray_dir_y;

    // whole pipeline freezes while the fifo is full
    assign advance = setup_ready;
    assign issue = issuing && advance;

    // ************************************************************
    // stage one, camera_x = c * 512 / num_columns - 256
    // ************************************************************
    assign cam_scaled = {col_cnt, 9'd0};
    assign cam_div = cam_scaled / num_cols_w;
    // quotient stays below 512 for any valid column
    assign camera_x = $signed({1'b0, cam_div[8:0]}) - 10'sd256;
    assign prod_x = $signed(raycast_pkg::pose_plane_x[pose_q]) * camera_x;
    assign prod_y = $signed(raycast_pkg::pose_plane_y[pose_q]) * camera_x;

    // ************************************************************
    // stage two, dir + (plane * camera_x) >>> 8, wraps at 16 bits
    // ************************************************************
    assign ray_dir_x = raycast_pkg::pose_dir_x[pose_q] + s1_prod_x[raycast_pkg::frac_bits +: fw];
    assign ray_dir_y = raycast_pkg::pose_dir_y[pose_q] + s1_prod_y[raycast_pkg::frac_bits +: fw];

    // frame start, column issue, busy release
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            busy <= 1'b0;
            issuing <= 1'b0;
            col_cnt <= '0;
            pose_q <= '0;
        end else if (start && !busy) begin
            busy <= 1'b1;
            issuing <= 1'b1;
            col_cnt <= '0;
            pose_q <= pose_sel;
        end else begin
            if (issue) begin
                if (col_cnt == last_col) begin
                    issuing <= 1'b0;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
            // drop busy once the last record is in the fifo
            if (setup_valid && setup_ready && setup_rec[raycast_pkg::rec_last_bit]) begin
                busy <= 1'b0;
            end
        end
    end

    // valid bits of both stages
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            s1_valid <= 1'b0;
            setup_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= issue;
            setup_valid <= s1_valid;
        end
    end

    // data path, moves with the valid bits
    always_ff @(posedge clk_pixel) begin
        if (advance) begin
            s1_col <= col_cnt;
            s1_last <= (col_cnt == last_col);
            s1_prod_x <= prod_x;
            s1_prod_y <= prod_y;
            setup_rec[raycast_pkg::rec_col_lsb +: cw] <= s1_col;
            setup_rec[raycast_pkg::rec_last_bit] <= s1_last;
            // step toward negative when the component is negative
            setup_rec[raycast_pkg::rec_step_x_bit] <= ray_dir_x[fw-1];
            setup_rec[raycast_pkg::rec_step_y_bit] <= ray_dir_y[fw-1];
            setup_rec[raycast_pkg::rec_dir_x_lsb +: fw] <= ray_dir_x;
            setup_rec[raycast_pkg::rec_dir_y_lsb +: fw] <= ray_dir_y;
        end
    end

endmodule

`default_nettype wire

/* rtl/ray_fifo.sv */
`default_nettype none

module ray_fifo #(
    parameter int fifo_depth = 16,
    parameter int width = 44
) (
    input logic clk_pixel,
    input logic sys_rst,
    input logic setup_valid,
    input logic [width-1:0] setup_rec,
    input logic fifo_ready,
    output logic setup_ready,
    output logic fifo_valid,
    output logic [width-1:0] fifo_rec
);

    localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_width = $clog2(fifo_depth + 1);
    localparam logic [ptr_width-1:0] ptr_last = ptr_width'(fifo_depth - 1);
    localparam logic [cnt_width-1:0] cnt_full = cnt_width'(fifo_depth);

    // record storage
    logic [width-1:0] mem [fifo_depth];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;
    logic wr_en;
    logic rd_en;

    // full and empty straight from the count
    assign setup_ready = (count != cnt_full);
    assign fifo_valid = (count != '0);
    assign wr_en = setup_valid && setup_ready;
    assign rd_en = fifo_valid && fifo_ready;

    // head of queue, readable right after the write edge
    assign fifo_rec = mem[rd_ptr];

    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            mem[wr_ptr] <= setup_rec;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            // pointers wrap at the depth, which need not be a power of two
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
            end
            // read and write together leave the count alone
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* delta_dist/delta_dist_unit.sv */
`default_nettype none

module delta_dist_unit (
    input logic clk_pixel,
    input logic sys_rst,
    input logic fifo_valid,
    input logic [raycast_pkg::setup_rec_width-1:0] fifo_rec,
    input logic ray_ready,
    output logic fifo_ready,
    output logic ray_valid,
    output logic [raycast_pkg::column_width-1:0] ray_column,
    output logic ray_last,
    output logic [raycast_pkg::fixed_width-1:0] ray_dir_x,
    output logic [raycast_pkg::fixed_width-1:0] ray_dir_y,
    output logic step_x,
    output logic step_y,
    output logic [raycast_pkg::fixed_width-1:0] delta_dist_x,
    output logic [raycast_pkg::fixed_width-1:0] delta_dist_y
);

    localparam int fw = raycast_pkg::fixed_width;

    typedef enum logic [1:0] {
        st_idle,
        st_divide,
        st_present
    } state_t;

    state_t state;

    // held copy of the accepted record
    logic [raycast_pkg::setup_rec_width-1:0] rec_q;
    logic accept;
    logic [fw-1:0] in_dir_x;
    logic [fw-1:0] in_dir_y;
    logic [fw-1:0] mag_x;
    logic [fw-1:0] mag_y;
    logic done_x;
    logic done_y;
    logic [fw-1:0] quot_x;
    logic [fw-1:0] quot_y;

    // take a new record only when idle
    assign fifo_ready = (state == st_idle);
    assign accept = fifo_valid && fifo_ready;

    // magnitude from the step bit, which is the sign
    assign in_dir_x = fifo_rec[raycast_pkg::rec_dir_x_lsb +: fw];
    assign in_dir_y = fifo_rec[raycast_pkg::rec_dir_y_lsb +: fw];
    assign mag_x = fifo_rec[raycast_pkg::rec_step_x_bit] ? -in_dir_x : in_dir_x;
    assign mag_y = fifo_rec[raycast_pkg::rec_step_y_bit] ? -in_dir_y : in_dir_y;

    // both dividers start on the accept cycle and finish together
    recip_divider recip_x_inst (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .go(accept),
        .magnitude(mag_x),
        .done(done_x),
        .quotient(quot_x)
    );

    recip_divider recip_y_inst (
        .clk_pixel(clk_pixel),
        .sys_rst(sys_rst),
        .go(accept),
        .magnitude(mag_y),
        .done(done_y),
        .quotient(quot_y)
    );

    // ************************************************************
    // idle -> divide -> present
    // ************************************************************
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (accept) state <= st_divide;
                st_divide: if (done_x && done_y) state <= st_present;
                st_present: if (ray_ready) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // record and results, held until taken
    always_ff @(posedge clk_pixel) begin
        if (accept) begin
            rec_q <= fifo_rec;
        end
        if (state == st_divide && done_x && done_y) begin
            delta_dist_x <= quot_x;
            delta_dist_y <= quot_y;
        end
    end

    assign ray_valid = (state == st_present);
    assign ray_column = rec_q[raycast_pkg::rec_col_lsb +: raycast_pkg::column_width];
    assign ray_last = rec_q[raycast_pkg::rec_last_bit];
    assign ray_dir_x = rec_q[raycast_pkg::rec_dir_x_lsb +: fw];
    assign ray_dir_y = rec_q[raycast_pkg::rec_dir_y_lsb +: fw];
    assign step_x = rec_q[raycast_pkg::rec_step_x_bit];
    assign step_y = rec_q[raycast_pkg::rec_step_y_bit];

endmodule

`default_nettype wire

/* delta_dist/recip_divider.sv */
`default_nettype none

module recip_divider (
    input logic clk_pixel,
    input logic sys_rst,
    input logic go,
    input logic [raycast_pkg::fixed_width-1:0] magnitude,
    output logic done,
    output logic [raycast_pkg::fixed_width-1:0] quotient
);

    localparam int fw = raycast_pkg::fixed_width;
    // steps after the one taken on the go edge
    localparam logic [4:0] more_steps = 5'(fw);
    // dividend 0x10000 shifts in a one first, zeros after
    localparam logic [fw:0] first_trial = (fw+1)'(1);

    logic running;
    logic [4:0] steps_left;
    logic [fw-1:0] divisor;
    logic [fw-1:0] rem;
    logic [fw:0] quo;

    // one restoring step
    logic [fw-1:0] div_cur;
    logic [fw:0] trial;
    logic [fw:0] trial_diff;
    logic fits;

    // first step runs straight off the input magnitude
    assign div_cur = go ? magnitude : divisor;
    assign trial = go ? first_trial : {rem, 1'b0};
    assign trial_diff = trial - {1'b0, div_cur};
    assign fits = (trial >= {1'b0, div_cur});

    // step counter and done pulse
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            running <= 1'b0;
            steps_left <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (go) begin
                running <= 1'b1;
                steps_left <= more_steps;
            end else if (running) begin
                steps_left <= steps_left - 1'b1;
                if (steps_left == 5'd1) begin
                    running <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // remainder stays below the divisor, so 16 bits hold it
    always_ff @(posedge clk_pixel) begin
        if (go || running) begin
            divisor <= div_cur;
            rem <= fits ? trial_diff[fw-1:0] : trial[fw-1:0];
            quo <= go ? {{fw{1'b0}}, fits} : {quo[fw-1:0], fits};
        end
    end

    // divide by zero or by one overflows 16 bits
    assign quotient = (divisor == '0 || quo[fw]) ? raycast_pkg::recip_saturate : quo[fw-1:0];

endmodule

`default_nettype wire

/* common/raycast_pkg.sv */
`default_nettype none

package raycast_pkg;

    // ************************************************************
    // fixed point format
    // ************************************************************

    // Q8.8 signed, two's complement
    localparam int fixed_width = 16;
    localparam int frac_bits = 8;

    // column index, room for up to 512 columns
    localparam int column_width = 9;

    // four preset poses
    localparam int pose_sel_width = 2;

    // ************************************************************
    // ray record layout
    // ************************************************************

    // ray_dir_y sits in the low word, column index on top
    localparam int rec_dir_y_lsb = 0;
    localparam int rec_dir_x_lsb = rec_dir_y_lsb + fixed_width;
    localparam int rec_step_y_bit = rec_dir_x_lsb + fixed_width;
    localparam int rec_step_x_bit = rec_step_y_bit + 1;
    localparam int rec_last_bit = rec_step_x_bit + 1;
    localparam int rec_col_lsb = rec_last_bit + 1;

    // column, last, two step bits and two direction words
    localparam int setup_rec_width = rec_col_lsb + column_width;

    // ************************************************************
    // preset camera poses
    // ************************************************************

    // 0x0100 is 1.0, 0xff00 is -1.0, 0x00a9 is about 0.66
    // pose 2 is the same view as pose 1, only its position differed
    localparam logic [fixed_width-1:0] pose_dir_x [2**pose_sel_width] = '{
        16'h0100, 16'hff00, 16'hff00, 16'h0000
    };
    localparam logic [fixed_width-1:0] pose_dir_y [2**pose_sel_width] = '{
        16'h0000, 16'h0000, 16'h0000, 16'h0100
    };

    // camera plane, perpendicular to the direction
    localparam logic [fixed_width-1:0] pose_plane_x [2**pose_sel_width] = '{
        16'h0000, 16'h0000, 16'h0000, 16'h00a9
    };
    localparam logic [fixed_width-1:0] pose_plane_y [2**pose_sel_width] = '{
        16'h00a9, 16'h00a9, 16'h00a9, 16'h0000
    };

    // reciprocal of zero or of a very small component
    localparam logic [fixed_width-1:0] recip_saturate = '1;

endpackage

`default_nettype wire
